// File: Makefile
TOP := tb_arcade_frontend

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: all.f
+incdir+design
design/arcade_pkg.sv
design/reset_ctrl.sv
design/coin_pulse.sv
design/player_map.sv
design/sigma_delta_dac.sv
design/arcade_frontend.sv
verif/tb_arcade_frontend.sv

// File: design/arcade_frontend.sv
`timescale 1ns/10ps
`default_nettype none

`include "arcade_params.svh"

module arcade_frontend
	import arcade_pkg::*;
(
	input  logic                                clk_sys,
	input  logic                                rst_n_i,
	input  logic [`STATUS_W-1:0]                status_i,
	input  logic [1:0]                          buttons_i,
	input  logic                                download_i,
	input  logic [`NUM_PLAYERS-1:0][`JOY_W-1:0] joystick_i,
	input  logic                                vblank_i,
	input  sample_t                             audio_i,
	output logic                                core_reset_o,
	output options_t                            options_o,
	output player_t [`NUM_PLAYERS-1:0]          players_o,
	output logic [`NUM_PLAYERS-1:0]             start_o,
	output logic [`NUM_PLAYERS-1:0]             coin_o,
	output logic                                audio_l_o,
	output logic                                audio_r_o
);

	logic      soft_reset;
	cab_ctrl_t cab;
	logic      dac_bit;

	// DIP banks are active low in the option word
	always_comb begin
		options_o.dswa      = ~status_i[`OPT_DSWA_LO +: `DIP_W];
		options_o.dswb      = ~status_i[`OPT_DSWB_LO +: `DIP_W];
		options_o.joyswap   = status_i[`OPT_JOYSWAP];
		options_o.pause     = status_i[`OPT_PAUSE];
		options_o.filter_en = ~status_i[`OPT_FILTER_OFF];
	end

	// Menu reset or the cabinet reset button
	assign soft_reset = status_i[`OPT_RESET] | buttons_i[1];

	reset_ctrl u_reset (
		.clk_sys      (clk_sys),
		.rst_n_i      (rst_n_i),
		.download_i   (download_i),
		.soft_reset_i (soft_reset),
		.core_reset_o (core_reset_o)
	);

	player_map u_players (
		.clk_sys    (clk_sys),
		.rst_n_i    (rst_n_i),
		.joystick_i (joystick_i),
		.joyswap_i  (options_o.joyswap),
		.players_o  (players_o),
		.cab_o      (cab)
	);

	assign start_o = cab.start;

	// one pulse generator per coin slot
	for (genvar i = 0; i < `NUM_PLAYERS; i++) begin : g_coin
		coin_pulse u_coin (
			.clk_sys  (clk_sys),
			.rst_n_i  (rst_n_i),
			.button_i (cab.coin[i]),
			.vblank_i (vblank_i),
			.pulse_o  (coin_o[i])
		);
	end

	sigma_delta_dac u_dac (
		.clk_sys  (clk_sys),
		.rst_n_i  (rst_n_i),
		.sample_i (audio_i),
		.dac_o    (dac_bit)
	);

	// Mono source, same stream on both speakers
	assign audio_l_o = dac_bit;
	assign audio_r_o = dac_bit;

endmodule

`default_nettype wire

// File: design/arcade_params.svh
`ifndef ARCADE_PARAMS_SVH
`define ARCADE_PARAMS_SVH

// Host option word
`define STATUS_W 32

// Raw joystick word from the host
`define JOY_W 16

`define NUM_PLAYERS 4

// Signed audio sample from the core
`define AUDIO_W 16

// Coin pulse length in video frames
`define COIN_FRAMES 3

// DIP switch bank width
`define DIP_W 8

// Bit positions in the option word
`define OPT_RESET 0
`define OPT_JOYSWAP 6
`define OPT_PAUSE 8
`define OPT_FILTER_OFF 15
`define OPT_DSWA_LO 16
`define OPT_DSWB_LO 24

`endif

// File: design/arcade_pkg.sv
`default_nettype none

`include "arcade_params.svh"

package arcade_pkg;

	// Same bit order as the low ten bits of a raw joystick word
	typedef struct packed {
		logic [5:0] fire;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} player_t;

	// Player 1 in bit 0 of each field
	typedef struct packed {
		logic [`NUM_PLAYERS-1:0] start;
		logic [`NUM_PLAYERS-1:0] coin;
	} cab_ctrl_t;

	// Options as the game core wants them
	typedef struct packed {
		logic [`DIP_W-1:0] dswa;
		logic [`DIP_W-1:0] dswb;
		logic              joyswap;
		logic              pause;
		logic              filter_en;
	} options_t;

	typedef logic signed [`AUDIO_W-1:0] sample_t;

	// Wide enough to hold the full frame count
	typedef logic [$clog2(`COIN_FRAMES + 1)-1:0] frame_cnt_t;

	typedef enum logic {
		ROM_EMPTY,
		ROM_LOADED
	} rom_state_t;

endpackage

`default_nettype wire

// File: design/coin_pulse.sv
`timescale 1ns/10ps
`default_nettype none

`include "arcade_params.svh"

module coin_pulse
	import arcade_pkg::*;
(
	input  logic clk_sys,
	input  logic rst_n_i,
	input  logic button_i,
	input  logic vblank_i,
	output logic pulse_o
);

	logic       button_q;
	logic       vblank_q;
	logic       press;
	logic       vblank_rise;
	frame_cnt_t frames_left;
	frame_cnt_t edges_seen;

	assign press       = button_i & ~button_q;
	assign vblank_rise = vblank_i & ~vblank_q;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			button_q <= 1'b0;
			vblank_q <= 1'b0;
		end else begin
			button_q <= button_i;
			vblank_q <= vblank_i;
		end
	end

	// Pulse stays high while frames remain
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			frames_left <= '0;
		end else if (!pulse_o) begin
			if (press) begin
				frames_left <= frame_cnt_t'(`COIN_FRAMES);
			end
		end else if (vblank_rise) begin
			frames_left <= frames_left - 1'b1;
		end
	end

	assign pulse_o = (frames_left != '0);

	// Counts up frames seen during the pulse
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i || !pulse_o) begin
			edges_seen <= '0;
		end else if (vblank_rise) begin
			edges_seen <= edges_seen + 1'b1;
		end
	end

	a_pulse_frames: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		pulse_o |-> edges_seen < frame_cnt_t'(`COIN_FRAMES));

endmodule

`default_nettype wire

// File: design/player_map.sv
`timescale 1ns/10ps
`default_nettype none

`include "arcade_params.svh"

module player_map
	import arcade_pkg::*;
(
	input  logic                                clk_sys,
	input  logic                                rst_n_i,
	input  logic [`NUM_PLAYERS-1:0][`JOY_W-1:0] joystick_i,
	input  logic                                joyswap_i,
	output player_t [`NUM_PLAYERS-1:0]          players_o,
	output cab_ctrl_t                           cab_o
);

	// Cabinet buttons in the raw word
	localparam int unsigned JOY_START = 10;
	localparam int unsigned JOY_COIN  = 11;
	localparam int unsigned CTRL_W    = $bits(player_t);

	logic [`NUM_PLAYERS-1:0][`JOY_W-1:0] raw;
	player_t [`NUM_PLAYERS-1:0]          players_d;
	cab_ctrl_t                           cab_d;

	// Player 1 and 2 exchange places on request
	always_comb begin
		raw = joystick_i;
		if (joyswap_i) begin
			raw[0] = joystick_i[1];
			raw[1] = joystick_i[0];
		end
	end

	always_comb begin
		cab_d = '0;
		for (int p = 0; p < `NUM_PLAYERS; p++) begin
			players_d[p]   = player_t'(raw[p][CTRL_W-1:0]);
			cab_d.start[p] = raw[p][JOY_START];
			cab_d.coin[p]  = raw[p][JOY_COIN];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			players_o <= '0;
			cab_o     <= '0;
		end else begin
			players_o <= players_d;
			cab_o     <= cab_d;
		end
	end

endmodule

`default_nettype wire

// File: design/reset_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module reset_ctrl
	import arcade_pkg::*;
(
	input  logic clk_sys,
	input  logic rst_n_i,
	input  logic download_i,
	input  logic soft_reset_i,
	output logic core_reset_o
);

	logic       download_q;
	rom_state_t rom_state;
	logic       download_fall;

	assign download_fall = download_q & ~download_i;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			download_q <= 1'b0;
		end else begin
			download_q <= download_i;
		end
	end

	// Sticky until the next board reset
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			rom_state <= ROM_EMPTY;
		end else if (download_fall) begin
			rom_state <= ROM_LOADED;
		end
	end

	// Core held in reset until a ROM image is in place
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			core_reset_o <= 1'b1;
		end else begin
			core_reset_o <= download_i | soft_reset_i | (rom_state != ROM_LOADED);
		end
	end

	a_reset_during_download: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		download_i |=> core_reset_o);

endmodule

`default_nettype wire

// File: design/sigma_delta_dac.sv
`timescale 1ns/10ps
`default_nettype none

`include "arcade_params.svh"

module sigma_delta_dac
	import arcade_pkg::*;
(
	input  logic    clk_sys,
	input  logic    rst_n_i,
	input  sample_t sample_i,
	output logic    dac_o
);

	logic [`AUDIO_W-1:0] offset;
	logic [`AUDIO_W-1:0] acc;
	logic [`AUDIO_W:0]   sum;

	// Two's complement to offset binary
	assign offset = {~sample_i[`AUDIO_W-1], sample_i[`AUDIO_W-2:0]};

	assign sum = {1'b0, acc} + {1'b0, offset};

	// Carry out forms the bit stream whose density tracks the sample
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			acc   <= '0;
			dac_o <= 1'b0;
		end else begin
			acc   <= sum[`AUDIO_W-1:0];
			dac_o <= sum[`AUDIO_W];
		end
	end

endmodule

`default_nettype wire

// File: verif/arcade_testdata.txt
# kind status btn dl joy0 joy1 joy2 joy3 audio hold exp_a exp_b (all hex)
# kind 0 core_reset_o, 1 options_o, 2 players_o/start_o, 3 coin edges/frames, 4 DAC ones
0 00000000 0 1 0000 0000 0000 0000 0000 3 1 0
0 00000000 0 0 0000 0000 0000 0000 0000 1 1 0
0 00000000 0 0 0000 0000 0000 0000 0000 1 0 0
0 00000001 0 0 0000 0000 0000 0000 0000 2 1 0
0 00000000 0 0 0000 0000 0000 0000 0000 2 0 0
0 00000000 2 0 0000 0000 0000 0000 0000 2 1 0
0 00000000 0 0 0000 0000 0000 0000 0000 2 0 0
0 00000000 1 0 0000 0000 0000 0000 0000 2 0 0
0 00000000 0 1 0000 0000 0000 0000 0000 2 1 0
0 00000000 0 0 0000 0000 0000 0000 0000 2 0 0
1 00000000 0 0 0000 0000 0000 0000 0000 1 7FFF9 0
1 12348140 0 0 0000 0000 0000 0000 0000 1 65F6E 0
1 A55A0000 0 0 0000 0000 0000 0000 0000 1 52AD1 0
1 00FF0100 0 0 0000 0000 0000 0000 0000 1 7FB 0
2 00000000 0 0 0401 0012 03FF 0000 0000 2 003FF04801 1
2 00000000 0 0 0020 0408 0404 07C3 0000 2 F0C0402020 E
2 00000040 0 0 0401 0012 03FF 0000 0000 2 003FF00412 2
2 00000000 0 0 0000 0000 0000 0000 0000 2 0 0
3 00000000 0 0 0800 0000 0000 0000 0000 4 0001 0
3 00000000 0 0 0000 0000 0000 0000 0000 4 0000 0
3 00000000 0 0 0800 0000 0000 0000 0000 4 0000 0
3 00000000 0 0 0000 0000 0000 0000 0000 3C 0000 3
3 00000000 0 0 0000 0000 0800 0000 0000 3C 0100 3
3 00000000 0 0 0000 0000 0000 0000 0000 A 0000 0
3 00000000 0 0 0000 0800 0000 0000 0000 3C 0010 3
3 00000000 0 0 0000 0000 0000 0000 0000 A 0000 0
3 00000040 0 0 0000 0800 0000 0000 0000 3C 0001 3
3 00000040 0 0 0000 0000 0000 0000 0000 A 0000 0
4 00000000 0 0 0000 0000 0000 0000 0000 10000 8000 0
4 00000000 0 0 0000 0000 0000 0000 5A5A 10000 DA5A 0
4 00000000 0 0 0000 0000 0000 0000 8001 10000 0001 0

// File: verif/tb_arcade_frontend.sv
`timescale 1ns/10ps
`default_nettype none

`include "arcade_params.svh"

module tb_arcade_frontend
	import arcade_pkg::*;
();

	localparam int    CLK_PERIOD = 100;
	localparam int    MAX_STEPS  = 64;
	localparam string DATA_FILE  = "verif/arcade_testdata.txt";

	localparam logic [3:0] STEP_RESET   = 4'h0;
	localparam logic [3:0] STEP_OPTIONS = 4'h1;
	localparam logic [3:0] STEP_PLAYERS = 4'h2;
	localparam logic [3:0] STEP_COIN    = 4'h3;
	localparam logic [3:0] STEP_DAC     = 4'h4;

	// One line of the data file
	typedef struct packed {
		logic [3:0]                          kind;
		logic [`STATUS_W-1:0]                status;
		logic [1:0]                          buttons;
		logic                                download;
		logic [`NUM_PLAYERS-1:0][`JOY_W-1:0] joy;
		logic [`AUDIO_W-1:0]                 audio;
		logic [31:0]                         hold;
		logic [63:0]                         exp_a;
		logic [63:0]                         exp_b;
	} step_t;

	logic                                clk_sys;
	logic                                rst_n_i;
	logic [`STATUS_W-1:0]                status_i;
	logic [1:0]                          buttons_i;
	logic                                download_i;
	logic [`NUM_PLAYERS-1:0][`JOY_W-1:0] joystick_i;
	logic                                vblank_i;
	sample_t                             audio_i;
	logic                                core_reset_o;
	options_t                            options_o;
	player_t [`NUM_PLAYERS-1:0]          players_o;
	logic [`NUM_PLAYERS-1:0]             start_o;
	logic [`NUM_PLAYERS-1:0]             coin_o;
	logic                                audio_l_o;
	logic                                audio_r_o;

	step_t                   steps [MAX_STEPS];
	int                      num_steps;
	int                      step_idx;
	int                      total_cycles;
	int                      errors;
	logic                    steps_loaded;
	int                      ones;
	int                      frames;
	logic [3:0]              edges [`NUM_PLAYERS];
	logic [`NUM_PLAYERS-1:0] coin_prev;

	arcade_frontend dut_i (
		.clk_sys      (clk_sys),
		.rst_n_i      (rst_n_i),
		.status_i     (status_i),
		.buttons_i    (buttons_i),
		.download_i   (download_i),
		.joystick_i   (joystick_i),
		.vblank_i     (vblank_i),
		.audio_i      (audio_i),
		.core_reset_o (core_reset_o),
		.options_o    (options_o),
		.players_o    (players_o),
		.start_o      (start_o),
		.coin_o       (coin_o),
		.audio_l_o    (audio_l_o),
		.audio_r_o    (audio_r_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("error: %s expected %h got %h (step %0d)", name, expected, actual, step_idx);
			errors++;
		end
	endtask

	task automatic load_steps();
		int          fd;
		int          n;
		string       line;
		logic [63:0] kind, status, btn, dl, j0, j1, j2, j3, audio, hold, ea, eb;
		num_steps    = 0;
		total_cycles = 0;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the test data file %s", DATA_FILE);
			return;
		end
		while (!$feof(fd) && num_steps < MAX_STEPS) begin
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
					kind, status, btn, dl, j0, j1, j2, j3, audio, hold, ea, eb);
				if (n == 12) begin
					steps[num_steps].kind     = kind[3:0];
					steps[num_steps].status   = status[`STATUS_W-1:0];
					steps[num_steps].buttons  = btn[1:0];
					steps[num_steps].download = dl[0];
					steps[num_steps].joy      = {j3[15:0], j2[15:0], j1[15:0], j0[15:0]};
					steps[num_steps].audio    = audio[`AUDIO_W-1:0];
					steps[num_steps].hold     = hold[31:0];
					steps[num_steps].exp_a    = ea;
					steps[num_steps].exp_b    = eb;
					total_cycles += int'(hold[31:0]);
					num_steps++;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic drive_step(input step_t s);
		status_i   = s.status;
		buttons_i  = s.buttons;
		download_i = s.download;
		joystick_i = s.joy;
		audio_i    = s.audio;
	endtask

	// Called right after a falling edge when outputs have settled
	task automatic sample_outputs();
		assert (audio_r_o === audio_l_o) else begin
			$display("error: audio_r_o expected %h got %h (step %0d)",
				audio_l_o, audio_r_o, step_idx);
			errors++;
		end
		if (audio_l_o) ones++;
		for (int b = 0; b < `NUM_PLAYERS; b++) begin
			if (coin_o[b] && !coin_prev[b]) edges[b] = edges[b] + 4'd1;
		end
		coin_prev = coin_o;
	endtask

	// Frame is 10 cycles with vblank high for two of them
	task automatic run_cycles(input int hold, input logic frames_on);
		logic vb;
		for (int c = 1; c <= hold; c++) begin
			@(negedge clk_sys);
			sample_outputs();
			vb = frames_on && ((c % 10) == 5 || (c % 10) == 6);
			if (vb && !vblank_i && coin_o != '0) frames++;
			vblank_i = vb;
		end
	endtask

	task automatic run_step(input step_t s);
		logic [4*`NUM_PLAYERS-1:0] edge_word;
		ones   = 0;
		frames = 0;
		for (int b = 0; b < `NUM_PLAYERS; b++) edges[b] = 4'd0;
		drive_step(s);
		// DAC count only holds from a fresh accumulator
		if (s.kind == STEP_DAC) begin
			rst_n_i = 1'b0;
			repeat (5) @(negedge clk_sys);
			rst_n_i = 1'b1;
		end
		run_cycles(int'(s.hold), s.kind == STEP_COIN);
		for (int b = 0; b < `NUM_PLAYERS; b++) edge_word[b*4 +: 4] = edges[b];
		case (s.kind)
			STEP_RESET: check_value("core_reset_o", s.exp_a, 64'(core_reset_o));
			STEP_OPTIONS: check_value("options_o", s.exp_a, 64'(options_o));
			STEP_PLAYERS: begin
				check_value("players_o", s.exp_a, 64'(players_o));
				check_value("start_o", s.exp_b, 64'(start_o));
			end
			STEP_COIN: begin
				check_value("coin_o rising edges", s.exp_a, 64'(edge_word));
				check_value("coin_o frames", s.exp_b, 64'(frames));
			end
			STEP_DAC: check_value("audio_l_o ones", s.exp_a, 64'(ones));
			default: begin
				$display("Test step %0d has an unknown kind %0d", step_idx, s.kind);
				errors++;
			end
		endcase
	endtask

	initial begin
		rst_n_i      = 1'b0;
		status_i     = '0;
		buttons_i    = '0;
		download_i   = 1'b0;
		joystick_i   = '0;
		vblank_i     = 1'b0;
		audio_i      = '0;
		errors       = 0;
		step_idx     = 0;
		coin_prev    = '0;
		steps_loaded = 1'b0;
		load_steps();
		steps_loaded = 1'b1;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n_i = 1'b1;
		if (num_steps == 0) begin
			$display("No test steps were read from %s", DATA_FILE);
			errors++;
		end
		for (int i = 0; i < num_steps; i++) begin
			step_idx = i;
			run_step(steps[i]);
		end
		$display("Summary: %0d steps run, %0d errors", num_steps, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// Watchdog sized from the hold counts in the data file
	initial begin
		wait (steps_loaded);
		repeat (total_cycles + 1000) @(posedge clk_sys);
		$display("Timeout: the run did not finish within %0d cycles", total_cycles + 1000);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire
